// ==== Bender.yml ====
package:
  name: uart_tile

export_include_dirs:
  - include

sources:
  - hdl/ringPkg.sv
  - hdl/uartPkg.sv
  - hdl/uartTx.sv
  - hdl/uartRx.sv
  - hdl/uartRegs.sv
  - hdl/ringController.sv
  - hdl/uartTile.sv
  - target: simulation
    files:
      - sim/uartTileTb.sv

// ==== all.f ====
+incdir+include
hdl/ringPkg.sv
hdl/uartPkg.sv
hdl/uartTx.sv
hdl/uartRx.sv
hdl/uartRegs.sv
hdl/ringController.sv
hdl/uartTile.sv
sim/uartTileTb.sv

// ==== hdl/ringController.sv ====
// ====================
// two stage pass-through per ring; hits on addr[31:24] are consumed
// one injection slot per ring; forwarded traffic always wins
// responses addressed here are dropped since the tile issues no reads
// ====================
`timescale 1ns/1ps
`default_nettype none
`include "lotrTile_config.svh"

module ringController
    import ringPkg::*;
    import uartPkg::*;
(
    input  logic                  QClk,
    input  logic                  rstN,
    input  logic [7:0]            CoreID,
    // ring inputs
    input  logic                  RingReqInValidQ500H,
    input  logic [RequestorW-1:0] RingReqInRequestorQ500H,
    input  t_opcode               RingReqInOpcodeQ500H,
    input  logic [31:0]           RingReqInAddressQ500H,
    input  logic [31:0]           RingReqInDataQ500H,
    input  logic                  RingRspInValidQ500H,
    input  logic [RequestorW-1:0] RingRspInRequestorQ500H,
    input  t_opcode               RingRspInOpcodeQ500H,
    input  logic [31:0]           RingRspInAddressQ500H,
    input  logic [31:0]           RingRspInDataQ500H,
    // ring outputs
    output logic                  RingReqOutValidQ502H,
    output logic [RequestorW-1:0] RingReqOutRequestorQ502H,
    output t_opcode               RingReqOutOpcodeQ502H,
    output logic [31:0]           RingReqOutAddressQ502H,
    output logic [31:0]           RingReqOutDataQ502H,
    output logic                  RingRspOutValidQ502H,
    output logic [RequestorW-1:0] RingRspOutRequestorQ502H,
    output t_opcode               RingRspOutOpcodeQ502H,
    output logic [31:0]           RingRspOutAddressQ502H,
    output logic [31:0]           RingRspOutDataQ502H,
    // F2C
    output logic                  f2cReqValid,
    output t_opcode               f2cReqOpcode,
    output logic [RequestorW-1:0] f2cReqRequestor,
    output t_regSel               f2cReqRegSel,
    output logic [31:0]           f2cReqData,
    input  logic                  f2cRspValid,
    input  logic [RequestorW-1:0] f2cRspRequestor,
    input  logic [31:0]           f2cRspData,
    // C2F
    input  logic                  c2fReqValid,
    input  logic [31:0]           c2fReqData,
    output logic                  rspStall
);

// ==================== pipeline state
logic                  reqS1Valid;
logic [RequestorW-1:0] reqS1Requestor;
t_opcode               reqS1Opcode;
logic [31:0]           reqS1Addr;
logic [31:0]           reqS1Data;
logic                  reqS2Valid;
logic [RequestorW-1:0] reqS2Requestor;
t_opcode               reqS2Opcode;
logic [31:0]           reqS2Addr;
logic [31:0]           reqS2Data;
logic                  rspS1Valid;
logic [31:0]           rspS1Addr;
logic [RequestorW-1:0] rspS1Requestor;
t_opcode               rspS1Opcode;
logic [31:0]           rspS1Data;
logic                  rspS2Valid;
logic [RequestorW-1:0] rspS2Requestor;
t_opcode               rspS2Opcode;
logic [31:0]           rspS2Addr;
logic [31:0]           rspS2Data;
// injection slots
logic                  reqSlotValid;
logic [31:0]           reqSlotData;
logic                  rspSlotValid;
logic [RequestorW-1:0] rspSlotRequestor;
logic [31:0]           rspSlotData;
logic                  reqS1Hit;
logic                  rspS1Hit;

assign reqS1Hit = reqS1Addr[31:24] == CoreID;
assign rspS1Hit = rspS1Addr[31:24] == CoreID;

always_ff @(posedge QClk or negedge rstN) begin
    if (!rstN) begin
        reqS1Valid   <= 1'b0;
        reqS2Valid   <= 1'b0;
        rspS1Valid   <= 1'b0;
        rspS2Valid   <= 1'b0;
        reqSlotValid <= 1'b0;
        rspSlotValid <= 1'b0;
    end else begin
        reqS1Valid <= RingReqInValidQ500H;
        reqS2Valid <= reqS1Valid && !reqS1Hit;   // hits leave here
        rspS1Valid <= RingRspInValidQ500H;
        rspS2Valid <= rspS1Valid && !rspS1Hit;
        // slot drains in any cycle stage 2 is empty
        if (c2fReqValid)     reqSlotValid <= 1'b1;
        else if (!reqS2Valid) reqSlotValid <= 1'b0;
        if (f2cRspValid)     rspSlotValid <= 1'b1;
        else if (!rspS2Valid) rspSlotValid <= 1'b0;
    end
end

// payload registers
always_ff @(posedge QClk) begin
    reqS1Requestor <= RingReqInRequestorQ500H;
    reqS1Opcode    <= RingReqInOpcodeQ500H;
    reqS1Addr      <= RingReqInAddressQ500H;
    reqS1Data      <= RingReqInDataQ500H;
    reqS2Requestor <= reqS1Requestor;
    reqS2Opcode    <= reqS1Opcode;
    reqS2Addr      <= reqS1Addr;
    reqS2Data      <= reqS1Data;
    rspS1Requestor <= RingRspInRequestorQ500H;
    rspS1Opcode    <= RingRspInOpcodeQ500H;
    rspS1Addr      <= RingRspInAddressQ500H;
    rspS1Data      <= RingRspInDataQ500H;
    rspS2Requestor <= rspS1Requestor;
    rspS2Opcode    <= rspS1Opcode;
    rspS2Addr      <= rspS1Addr;
    rspS2Data      <= rspS1Data;
    if (c2fReqValid) reqSlotData <= c2fReqData;
    if (f2cRspValid) begin
        rspSlotRequestor <= f2cRspRequestor;
        rspSlotData      <= f2cRspData;
    end
end

// ==================== consume side
assign f2cReqValid     = reqS1Valid && reqS1Hit;
assign f2cReqOpcode    = reqS1Opcode;
assign f2cReqRequestor = reqS1Requestor;
assign f2cReqData      = reqS1Data;
assign rspStall        = reqSlotValid || rspSlotValid;  // any slot still waiting

always_comb begin
    unique case ({reqS1Addr[3:2], 2'b00})
        `REG_TXDATA: f2cReqRegSel = SEL_TXDATA;
        `REG_STATUS: f2cReqRegSel = SEL_STATUS;
        `REG_RXDATA: f2cReqRegSel = SEL_RXDATA;
        default:     f2cReqRegSel = SEL_NONE;
    endcase
end

// ==================== output muxes
always_comb begin
    RingReqOutValidQ502H = reqS2Valid || reqSlotValid;
    if (reqS2Valid) begin
        RingReqOutRequestorQ502H = reqS2Requestor;
        RingReqOutOpcodeQ502H    = reqS2Opcode;
        RingReqOutAddressQ502H   = reqS2Addr;
        RingReqOutDataQ502H      = reqS2Data;
    end else begin
        RingReqOutRequestorQ502H = {CoreID, 2'b00};     // thread 0
        RingReqOutOpcodeQ502H    = WR;
        RingReqOutAddressQ502H   = `UART_RX_DEST_ADDR;
        RingReqOutDataQ502H      = reqSlotData;
    end
    RingRspOutValidQ502H = rspS2Valid || rspSlotValid;
    if (rspS2Valid) begin
        RingRspOutRequestorQ502H = rspS2Requestor;
        RingRspOutOpcodeQ502H    = rspS2Opcode;
        RingRspOutAddressQ502H   = rspS2Addr;
        RingRspOutDataQ502H      = rspS2Data;
    end else begin
        RingRspOutRequestorQ502H = rspSlotRequestor;
        RingRspOutOpcodeQ502H    = RD_RSP;
        // route back to the requesting core
        RingRspOutAddressQ502H   = {rspSlotRequestor[RequestorW-1:2], 24'h0};
        RingRspOutDataQ502H      = rspSlotData;
    end
end

// register block must honour the stall or an injected item is lost
assert property (@(posedge QClk) disable iff (!rstN)
    (c2fReqValid |-> !reqSlotValid) and (f2cRspValid |-> !rspSlotValid));

endmodule

`default_nettype wire

// ==== hdl/ringPkg.sv ====
// ====================
// ring fabric types shared by every tile
// requestor = {coreId[7:0], threadId[1:0]}
// ====================
`default_nettype none

package ringPkg;

    // requestor field width
    localparam int RequestorW = 10;

    // ring opcodes, NOP is never consumed
    typedef enum logic [1:0] {
        RD     = 2'b00,
        RD_RSP = 2'b01,
        WR     = 2'b10,
        NOP    = 2'b11
    } t_opcode;

endpackage

`default_nettype wire

// ==== hdl/uartPkg.sv ====
// ====================
// UART side types; regSel comes from address bits 3:2
// ====================
`default_nettype none

package uartPkg;

    typedef enum logic [1:0] {
        SEL_TXDATA = 2'd0,
        SEL_STATUS = 2'd1,
        SEL_RXDATA = 2'd2,
        SEL_NONE   = 2'd3   // unmapped offset
    } t_regSel;

    // 8N1 receiver states
    typedef enum logic [1:0] {IDLE, START, DATA, STOP} t_rxState;

endpackage

`default_nettype wire

// ==== hdl/uartRegs.sv ====
// ====================
// TXDATA / STATUS / RXDATA register block
// one pending response and one pending rx byte, both held on rspStall
// a byte arriving while the ring cannot take it sets overrun
// ====================
`timescale 1ns/1ps
`default_nettype none

module uartRegs
    import ringPkg::*;
    import uartPkg::*;
(
    input  logic                  QClk,
    input  logic                  rstN,
    input  logic                  f2cReqValid,
    input  t_opcode               f2cReqOpcode,
    input  logic [RequestorW-1:0] f2cReqRequestor,
    input  t_regSel               f2cReqRegSel,
    input  logic [31:0]           f2cReqData,
    output logic                  f2cRspValid,
    output logic [RequestorW-1:0] f2cRspRequestor,
    output logic [31:0]           f2cRspData,
    output logic                  c2fReqValid,
    output logic [31:0]           c2fReqData,
    input  logic                  rspStall,
    output logic                  txStart,
    output logic [7:0]            txByte,
    input  logic                  txBusy,
    input  logic                  rxValid,
    input  logic [7:0]            rxByte
);

logic       rspPend;
logic       rxPend;
logic       rxFull;
logic       overrun;
logic [7:0] rxHold;
logic [31:0] readData;
logic       isRead;
logic       txWrite;
logic       rxAccept;

assign isRead   = f2cReqValid && f2cReqOpcode == RD;
assign txWrite  = f2cReqValid && f2cReqOpcode == WR && f2cReqRegSel == SEL_TXDATA;
assign rxAccept = rxValid && !rxPend && !rspStall;

always_comb begin
    unique case (f2cReqRegSel)
        SEL_STATUS: readData = {29'd0, overrun, rxFull, txBusy};
        SEL_RXDATA: readData = {24'd0, rxHold};
        default:    readData = '0;   // TXDATA reads back zero
    endcase
end

assign f2cRspValid = rspPend && !rspStall;
assign c2fReqValid = rxPend && !rspStall;
assign c2fReqData  = {24'd0, rxHold};

always_ff @(posedge QClk or negedge rstN) begin
    if (!rstN) begin
        rspPend <= 1'b0;
        rxPend  <= 1'b0;
        rxFull  <= 1'b0;
        overrun <= 1'b0;
        txStart <= 1'b0;
    end else begin
        txStart <= txWrite;          // tx ignores it while busy
        if (f2cRspValid) rspPend <= 1'b0;
        if (isRead)      rspPend <= 1'b1;    // newest read wins
        if (c2fReqValid) rxPend <= 1'b0;
        if (isRead && f2cReqRegSel == SEL_RXDATA) begin
            rxFull  <= 1'b0;
            overrun <= 1'b0;
        end
        // set after clear so a new byte survives a same cycle read
        if (rxAccept) begin
            rxPend <= 1'b1;
            rxFull <= 1'b1;
        end else if (rxValid) begin
            overrun <= 1'b1;         // byte dropped
        end
    end
end

always_ff @(posedge QClk) begin
    if (txWrite)  txByte <= f2cReqData[7:0];
    if (rxAccept) rxHold <= rxByte;
    if (isRead) begin
        f2cRspRequestor <= f2cReqRequestor;
        f2cRspData      <= readData;
    end
end

// responses never come back through the request path
assert property (@(posedge QClk) disable iff (!rstN)
    f2cReqValid |-> f2cReqOpcode != RD_RSP);

endmodule

`default_nettype wire

// ==== hdl/uartRx.sv ====
// ====================
// 8N1 receiver, two flop synchronizer, samples at mid bit
// glitch shorter than half a bit is rejected; low stop bit drops the byte
// rxByte is only meaningful while rxValid is high
// ====================
`timescale 1ns/1ps
`default_nettype none
`include "lotrTile_config.svh"

module uartRx
    import uartPkg::*;
(
    input  logic       QClk,
    input  logic       rstN,
    input  logic       uartRxd,
    output logic       rxValid,
    output logic [7:0] rxByte
);

localparam int ClksPerBit = `UART_CLKS_PER_BIT;
localparam int CntW = $clog2(ClksPerBit);

logic            rxMeta;
logic            rxSync;
t_rxState        state;
logic [CntW-1:0] baudCnt;
logic [2:0]      bitCnt;
logic [7:0]      shiftReg;
logic            halfDone;
logic            fullDone;

assign halfDone = baudCnt == CntW'(ClksPerBit / 2 - 1);
assign fullDone = baudCnt == CntW'(ClksPerBit - 1);
assign rxByte   = shiftReg;

always_ff @(posedge QClk or negedge rstN) begin
    if (!rstN) begin
        rxMeta <= 1'b1;
        rxSync <= 1'b1;
    end else begin
        rxMeta <= uartRxd;
        rxSync <= rxMeta;
    end
end

always_ff @(posedge QClk or negedge rstN) begin
    if (!rstN) begin
        state   <= IDLE;
        baudCnt <= '0;
        bitCnt  <= '0;
        rxValid <= 1'b0;
    end else begin
        rxValid <= 1'b0;
        baudCnt <= baudCnt + 1'b1;
        unique case (state)
            IDLE: begin
                baudCnt <= '0;
                if (!rxSync) state <= START;
            end
            START: if (halfDone) begin   // now aligned to mid bit
                baudCnt <= '0;
                bitCnt  <= '0;
                state   <= rxSync ? IDLE : DATA;
            end
            DATA: if (fullDone) begin
                baudCnt <= '0;
                bitCnt  <= bitCnt + 1'b1;
                if (bitCnt == 3'd7) state <= STOP;
            end
            STOP: if (fullDone) begin
                state   <= IDLE;
                rxValid <= rxSync;       // framing error drops it
            end
        endcase
    end
end

always_ff @(posedge QClk) begin
    if (state == DATA && fullDone) shiftReg <= {rxSync, shiftReg[7:1]};
end

assert property (@(posedge QClk) disable iff (!rstN)
    rxValid |-> $past(state) == STOP);

endmodule

`default_nettype wire

// ==== hdl/uartTile.sv ====
// ====================
// UART ring tile, CoreID must be stable out of reset
// ring in to out latency is 2 cycles for traffic not addressed here
// ====================
`timescale 1ns/1ps
`default_nettype none

module uartTile
    import ringPkg::*;
    import uartPkg::*;
(
    input  logic                  QClk,
    input  logic                  rstN,
    input  logic [7:0]            CoreID,
    input  logic                  RingReqInValidQ500H,
    input  logic [RequestorW-1:0] RingReqInRequestorQ500H,
    input  t_opcode               RingReqInOpcodeQ500H,
    input  logic [31:0]           RingReqInAddressQ500H,
    input  logic [31:0]           RingReqInDataQ500H,
    input  logic                  RingRspInValidQ500H,
    input  logic [RequestorW-1:0] RingRspInRequestorQ500H,
    input  t_opcode               RingRspInOpcodeQ500H,
    input  logic [31:0]           RingRspInAddressQ500H,
    input  logic [31:0]           RingRspInDataQ500H,
    output logic                  RingReqOutValidQ502H,
    output logic [RequestorW-1:0] RingReqOutRequestorQ502H,
    output t_opcode               RingReqOutOpcodeQ502H,
    output logic [31:0]           RingReqOutAddressQ502H,
    output logic [31:0]           RingReqOutDataQ502H,
    output logic                  RingRspOutValidQ502H,
    output logic [RequestorW-1:0] RingRspOutRequestorQ502H,
    output t_opcode               RingRspOutOpcodeQ502H,
    output logic [31:0]           RingRspOutAddressQ502H,
    output logic [31:0]           RingRspOutDataQ502H,
    input  logic                  uartRxd,
    output logic                  uartTxd
);

// ==================== F2C / C2F
logic                  f2cReqValid;
t_opcode               f2cReqOpcode;
logic [RequestorW-1:0] f2cReqRequestor;
t_regSel               f2cReqRegSel;
logic [31:0]           f2cReqData;
logic                  f2cRspValid;
logic [RequestorW-1:0] f2cRspRequestor;
logic [31:0]           f2cRspData;
logic                  c2fReqValid;
logic [31:0]           c2fReqData;
logic                  rspStall;
// serial side
logic                  txStart;
logic [7:0]            txByte;
logic                  txBusy;
logic                  rxValid;
logic [7:0]            rxByte;

// all names line up with the port names below
ringController rc0 (.*);
uartRegs       regs0 (.*);
uartTx         tx0 (.*);
uartRx         rx0 (.*);

endmodule

`default_nettype wire

// ==== hdl/uartTx.sv ====
// ====================
// 8N1 transmitter, fixed baud from the config header
// start bit begins the cycle after txStart; txStart while busy is dropped
// ====================
`timescale 1ns/1ps
`default_nettype none
`include "lotrTile_config.svh"

module uartTx (
    input  logic       QClk,
    input  logic       rstN,
    input  logic       txStart,
    input  logic [7:0] txByte,
    output logic       txBusy,
    output logic       uartTxd
);

localparam int ClksPerBit = `UART_CLKS_PER_BIT;
localparam int CntW = $clog2(ClksPerBit);

logic [CntW-1:0] baudCnt;
logic [3:0]      bitCnt;     // 0 = start, 9 = stop
logic [8:0]      shiftReg;   // {stop, data}
logic            bitDone;
logic            launch;

assign bitDone = baudCnt == CntW'(ClksPerBit - 1);
assign launch  = txStart && !txBusy;

always_ff @(posedge QClk or negedge rstN) begin
    if (!rstN) begin
        txBusy  <= 1'b0;
        uartTxd <= 1'b1;     // line idles high
        baudCnt <= '0;
        bitCnt  <= '0;
    end else if (launch) begin
        txBusy  <= 1'b1;
        uartTxd <= 1'b0;     // start bit
        baudCnt <= '0;
        bitCnt  <= '0;
    end else if (txBusy) begin
        baudCnt <= bitDone ? '0 : baudCnt + 1'b1;
        if (bitDone && bitCnt == 4'd9) begin
            txBusy  <= 1'b0;
            uartTxd <= 1'b1;
        end else if (bitDone) begin
            uartTxd <= shiftReg[0];   // LSB first
            bitCnt  <= bitCnt + 1'b1;
        end
    end
end

always_ff @(posedge QClk) begin
    if (launch)               shiftReg <= {1'b1, txByte};
    else if (txBusy && bitDone) shiftReg <= {1'b1, shiftReg[8:1]};
end

endmodule

`default_nettype wire

// ==== include/lotrTile_config.svh ====
// ====================
// UART tile build constants; baud rate is fixed at build time
// register offsets are byte addresses, only bits 3:2 are decoded
// ====================
`ifndef LOTR_TILE_CONFIG_SVH
`define LOTR_TILE_CONFIG_SVH

// clocks per serial bit, kept small for short sims
`define UART_CLKS_PER_BIT 8

// register offsets inside the tile
`define REG_TXDATA 4'h0
`define REG_STATUS 4'h4
`define REG_RXDATA 4'h8

// received bytes are written here, core 01 offset 0
`define UART_RX_DEST_ADDR 32'h0100_0000

`endif

// ==== sim/uartTileTb.sv ====
// ====================
// testbench for the UART ring tile, CoreID tied to 05
// serial model is 8N1 at `UART_CLKS_PER_BIT clocks per bit
// forwarded responses never carry RD_RSP, so tile read responses stay unambiguous
// ====================
`timescale 1ns/1ps
`default_nettype none
`include "lotrTile_config.svh"

module uartTileTb
    import ringPkg::*;
    import uartPkg::*;
();

localparam logic [7:0] TileId = 8'h05;
localparam int ClkPeriod     = 20;
localparam int BitClks       = `UART_CLKS_PER_BIT;
localparam int MaxTestCycles = 400;
localparam int TimeoutCycles = 10 * MaxTestCycles;  // six tests at most 400 each, plus margin
localparam int RspTimeout    = 100;
localparam int FieldW        = RequestorW + 2 + 64;  // {requestor, opcode, addr, data}

// ==================== DUT signals
logic                  QClk;
logic                  rstN;
logic [7:0]            CoreID;
logic                  RingReqInValidQ500H;
logic [RequestorW-1:0] RingReqInRequestorQ500H;
t_opcode               RingReqInOpcodeQ500H;
logic [31:0]           RingReqInAddressQ500H;
logic [31:0]           RingReqInDataQ500H;
logic                  RingRspInValidQ500H;
logic [RequestorW-1:0] RingRspInRequestorQ500H;
t_opcode               RingRspInOpcodeQ500H;
logic [31:0]           RingRspInAddressQ500H;
logic [31:0]           RingRspInDataQ500H;
logic                  RingReqOutValidQ502H;
logic [RequestorW-1:0] RingReqOutRequestorQ502H;
t_opcode               RingReqOutOpcodeQ502H;
logic [31:0]           RingReqOutAddressQ502H;
logic [31:0]           RingReqOutDataQ502H;
logic                  RingRspOutValidQ502H;
logic [RequestorW-1:0] RingRspOutRequestorQ502H;
t_opcode               RingRspOutOpcodeQ502H;
logic [31:0]           RingRspOutAddressQ502H;
logic [31:0]           RingRspOutDataQ502H;
logic                  uartRxd;
logic                  uartTxd;

// ==================== bookkeeping
int          errCount;
int          testCount;
int          failCount;
int          testStartErr;
int          cycleCount;
logic [31:0] gotRx[$];      // data of every injected rx write
logic [7:0]  txVal;
logic [7:0]  rxVal;
logic [7:0]  rxVal2;
logic [31:0] rdata;
// input copies delayed by two cycles, compared with the outputs
logic              reqD1Valid;
logic              reqD2Valid;
logic              rspD1Valid;
logic              rspD2Valid;
logic [FieldW-1:0] reqD1;
logic [FieldW-1:0] reqD2;
logic [FieldW-1:0] rspD1;
logic [FieldW-1:0] rspD2;
logic [FieldW-1:0] reqOutFields;
logic [FieldW-1:0] rspOutFields;

uartTile dut0 (.*);

always #(ClkPeriod / 2) QClk = ~QClk;

assign reqOutFields = {RingReqOutRequestorQ502H, RingReqOutOpcodeQ502H,
                       RingReqOutAddressQ502H, RingReqOutDataQ502H};
assign rspOutFields = {RingRspOutRequestorQ502H, RingRspOutOpcodeQ502H,
                       RingRspOutAddressQ502H, RingRspOutDataQ502H};

always @(posedge QClk) begin
    reqD1Valid <= RingReqInValidQ500H;
    reqD2Valid <= reqD1Valid;
    rspD1Valid <= RingRspInValidQ500H;
    rspD2Valid <= rspD1Valid;
    reqD1 <= {RingReqInRequestorQ500H, RingReqInOpcodeQ500H,
              RingReqInAddressQ500H, RingReqInDataQ500H};
    rspD1 <= {RingRspInRequestorQ500H, RingRspInOpcodeQ500H,
              RingRspInAddressQ500H, RingRspInDataQ500H};
    reqD2 <= reqD1;
    rspD2 <= rspD1;
end

// ==================== helpers
task automatic flagError(input string what);
    errCount++;
    $display("ERROR %s", what);
endtask

task automatic checkValue(input string name, input logic [31:0] expVal,
                          input logic [31:0] gotVal);
    assert (gotVal === expVal) else begin
        errCount++;
        $display("MISMATCH %s exp %h got %h", name, expVal, gotVal);
    end
endtask

function automatic logic [7:0] otherCore();
    logic [7:0] c;
    c = 8'($urandom);
    if (c == TileId) c = 8'h06;
    return c;
endfunction

// one cycle of random request traffic, hits carry NOP so the registers ignore them
task automatic driveReq(input logic valid, input logic toTile);
    RingReqInValidQ500H     <= valid;
    RingReqInRequestorQ500H <= RequestorW'($urandom);
    RingReqInOpcodeQ500H    <= toTile ? NOP : t_opcode'(2'($urandom));
    RingReqInAddressQ500H   <= {toTile ? TileId : otherCore(), 24'($urandom)};
    RingReqInDataQ500H      <= $urandom;
endtask

task automatic driveRsp(input logic valid, input logic toTile);
    t_opcode op;
    op = t_opcode'(2'($urandom));
    if (op == RD_RSP) op = NOP;
    RingRspInValidQ500H     <= valid;
    RingRspInRequestorQ500H <= RequestorW'($urandom);
    RingRspInOpcodeQ500H    <= op;
    RingRspInAddressQ500H   <= {toTile ? TileId : otherCore(), 24'($urandom)};
    RingRspInDataQ500H      <= $urandom;
endtask

// single request strobe addressed to this tile
task automatic ringAccess(input t_opcode op, input logic [3:0] offset,
                          input logic [RequestorW-1:0] who, input logic [31:0] wdata);
    @(posedge QClk);
    RingReqInValidQ500H     <= 1'b1;
    RingReqInRequestorQ500H <= who;
    RingReqInOpcodeQ500H    <= op;
    RingReqInAddressQ500H   <= {TileId, 20'h0, offset};
    RingReqInDataQ500H      <= wdata;
    @(posedge QClk);
    RingReqInValidQ500H     <= 1'b0;
endtask

task automatic readReg(input logic [3:0] offset, output logic [31:0] data);
    logic [RequestorW-1:0] who;
    int waited;
    who = {8'h40 | 8'($urandom_range(0, 63)), 2'($urandom)};   // never core 05
    ringAccess(RD, offset, who, 32'h0);
    waited = 0;
    @(negedge QClk);
    while (!(RingRspOutValidQ502H && RingRspOutOpcodeQ502H == RD_RSP)
           && waited < RspTimeout) begin
        @(negedge QClk);
        waited++;
    end
    if (waited >= RspTimeout) begin
        flagError("no read response on RingRspOut");
        data = '0;
    end else begin
        checkValue("RingRspOutRequestorQ502H", who, RingRspOutRequestorQ502H);
        data = RingRspOutDataQ502H;
    end
endtask

task automatic sendByte(input logic [7:0] b);
    logic [9:0] frame;
    int i;
    frame = {1'b1, b, 1'b0};    // start first, LSB first, stop last
    for (i = 0; i < 10; i++) begin
        @(posedge QClk);
        uartRxd <= frame[i];
        repeat (BitClks - 1) @(posedge QClk);
    end
endtask

// every clock of the frame is compared, so bit length is checked too
task automatic checkFrame(input logic [7:0] b);
    logic [9:0] frame;
    int waited;
    int c;
    frame = {1'b1, b, 1'b0};
    waited = 0;
    @(negedge QClk);
    while (uartTxd && waited < 50) begin
        @(negedge QClk);
        waited++;
    end
    if (uartTxd) begin
        flagError("no start bit on uartTxd");
    end else begin
        for (c = 0; c < 10 * BitClks; c++) begin
            checkValue("uartTxd", frame[c / BitClks], uartTxd);
            @(negedge QClk);
        end
    end
endtask

task automatic waitInjection(input int limit);
    int waited;
    waited = 0;
    while (gotRx.size() == 0 && waited < limit) begin
        @(posedge QClk);
        waited++;
    end
    if (gotRx.size() == 0) flagError("received byte never injected on RingReqOut");
endtask

task automatic startTest();
    testStartErr = errCount;
endtask

task automatic endTest(input string name);
    testCount++;
    if (errCount != testStartErr) failCount++;
    $display("test %0d %-24s %s", testCount, name, errCount == testStartErr ? "ok" : "FAILED");
endtask

// ==================== scoreboard, collects injected rx writes
always @(negedge QClk) begin
    if (rstN && RingReqOutValidQ502H && RingReqOutAddressQ502H == `UART_RX_DEST_ADDR) begin
        checkValue("RingReqOutRequestorQ502H", {TileId, 2'b00}, RingReqOutRequestorQ502H);
        checkValue("RingReqOutOpcodeQ502H", WR, RingReqOutOpcodeQ502H);
        gotRx.push_back(RingReqOutDataQ502H);
    end
end

// ==================== assertions
assert property (@(posedge QClk) $rose(rstN) |->
    !RingReqOutValidQ502H && !RingRspOutValidQ502H && uartTxd)
    else flagError("ring outputs busy or uartTxd low right after reset");

// forwarded traffic, all fields unchanged 2 cycles later
assert property (@(posedge QClk) disable iff (!rstN)
    reqD2Valid && reqD2[63:56] != TileId |->
    {RingReqOutValidQ502H, reqOutFields} == {1'b1, reqD2})
    else begin
        errCount++;
        $display("MISMATCH RingReqOutQ502H exp %h got %h", {1'b1, $sampled(reqD2)},
                 {$sampled(RingReqOutValidQ502H), $sampled(reqOutFields)});
    end

assert property (@(posedge QClk) disable iff (!rstN)
    rspD2Valid && rspD2[63:56] != TileId |->
    {RingRspOutValidQ502H, rspOutFields} == {1'b1, rspD2})
    else begin
        errCount++;
        $display("MISMATCH RingRspOutQ502H exp %h got %h", {1'b1, $sampled(rspD2)},
                 {$sampled(RingRspOutValidQ502H), $sampled(rspOutFields)});
    end

// consumed traffic never leaves
assert property (@(posedge QClk) disable iff (!rstN)
    RingReqOutValidQ502H |-> RingReqOutAddressQ502H[31:24] != TileId)
    else flagError("request addressed to this tile left on RingReqOut");

assert property (@(posedge QClk) disable iff (!rstN)
    RingRspOutValidQ502H |-> RingRspOutAddressQ502H[31:24] != TileId)
    else flagError("response addressed to this tile left on RingRspOut");

// ==================== run limit
initial begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
        @(posedge QClk);
        cycleCount++;
    end
    $display("timeout, run stopped after %0d cycles", cycleCount);
    $display("Done: errors found");
    $finish;
end

// ==================== tests
initial begin
    void'($urandom(19413));
    QClk = 1'b0;
    rstN = 1'b0;
    CoreID = TileId;
    uartRxd = 1'b1;            // idle line
    RingReqInValidQ500H = 1'b0;
    RingReqInRequestorQ500H = '0;
    RingReqInOpcodeQ500H = NOP;
    RingReqInAddressQ500H = '0;
    RingReqInDataQ500H = '0;
    RingRspInValidQ500H = 1'b0;
    RingRspInRequestorQ500H = '0;
    RingRspInOpcodeQ500H = NOP;
    RingRspInAddressQ500H = '0;
    RingRspInDataQ500H = '0;
    errCount = 0;
    testCount = 0;
    failCount = 0;
    repeat (2) @(posedge QClk);
    rstN <= 1'b1;

    startTest();
    repeat (3) @(posedge QClk);   // reset check fires in here
    endTest("reset state");

    startTest();
    repeat (200) begin
        @(posedge QClk);
        driveReq($urandom_range(0, 3) != 0, $urandom_range(0, 7) == 0);
        driveRsp($urandom_range(0, 3) != 0, $urandom_range(0, 7) == 0);
    end
    @(posedge QClk);
    RingReqInValidQ500H <= 1'b0;
    RingRspInValidQ500H <= 1'b0;
    repeat (4) @(posedge QClk);
    endTest("ring pass-through");

    startTest();
    txVal = 8'($urandom);
    ringAccess(WR, `REG_TXDATA, {8'h40, 2'b00}, {24'h0, txVal});
    fork
        checkFrame(txVal);
        begin
            repeat (20) @(posedge QClk);  // well inside the frame
            readReg(`REG_STATUS, rdata);
            checkValue("STATUS.txBusy", 32'h1, rdata[0]);
        end
    join
    endTest("serial transmit");

    startTest();
    gotRx.delete();
    rxVal = 8'($urandom);
    sendByte(rxVal);
    waitInjection(100);
    if (gotRx.size() > 0) checkValue("RingReqOutDataQ502H", {24'h0, rxVal}, gotRx.pop_front());
    checkValue("rx0.state", IDLE, dut0.rx0.state);
    endTest("serial receive to ring");

    startTest();
    gotRx.delete();
    rxVal = 8'($urandom);
    sendByte(rxVal);
    waitInjection(100);
    fork
        begin
            repeat (30) begin          // full response ring holds the read response back
                @(posedge QClk);
                driveRsp(1'b1, 1'b0);
            end
            @(posedge QClk);
            RingRspInValidQ500H <= 1'b0;
        end
        begin
            repeat (3) @(posedge QClk);
            readReg(`REG_RXDATA, rdata);
        end
    join
    checkValue("RXDATA", {24'h0, rxVal}, rdata);
    readReg(`REG_STATUS, rdata);
    checkValue("STATUS.rxFull", 32'h0, rdata[1]);
    endTest("RXDATA read under load");

    startTest();
    gotRx.delete();
    rxVal = 8'($urandom);
    rxVal2 = 8'($urandom);
    fork
        begin
            sendByte(rxVal);
            sendByte(rxVal2);
        end
        repeat (20 * BitClks + 8) begin    // request ring full past both stop bits
            @(posedge QClk);
            driveReq(1'b1, 1'b0);
        end
    join
    checkValue("injected count while saturated", 32'h0, gotRx.size());
    @(posedge QClk);
    RingReqInValidQ500H <= 1'b0;
    waitInjection(20);
    repeat (40) @(posedge QClk);
    checkValue("injected count", 32'h1, gotRx.size());
    if (gotRx.size() > 0) checkValue("RingReqOutDataQ502H", {24'h0, rxVal}, gotRx[0]);
    readReg(`REG_STATUS, rdata);
    checkValue("STATUS.overrun", 32'h1, rdata[2]);
    endTest("rx overrun");

    $display("tests %0d, failed %0d, errors %0d", testCount, failCount, errCount);
    if (errCount == 0)
        $display("Done: no errors");
    else
        $display("Done: errors found");
    $finish;
end

endmodule

`default_nettype wire
